// ==== bench/execute_golden.txt ====
# op pc op1 op2 op3 tag stall  jump target killed addr read strb wdata  we result
# op, tag, stall, jump, killed, read and we are decimal, all other columns hex
1 00001000 7fffffff 00000001 00000000 0 0  0 00001000 0 80000000 0 0 00000000  1 80000000
2 00001000 80000000 00000001 00000000 0 0  0 7fffffff 0 80000000 0 0 00000000  1 7fffffff
3 00001000 ffffffff 00000001 00000000 0 0  0 00001000 0 00000000 0 0 00000000  1 00000001
4 00001000 ffffffff 00000001 00000000 0 0  0 00001000 0 00000000 0 0 00000000  1 00000000
5 00001000 f0f0f0f0 ff00ff00 00000000 0 0  0 00001000 0 eff1eff0 0 0 00000000  1 0ff00ff0
6 00001000 f0f0f0f0 ff00ff00 00000000 0 0  0 00001000 0 eff1eff0 0 0 00000000  1 fff0fff0
7 00001000 f0f0f0f0 ff00ff00 00000000 0 0  0 00001000 0 eff1eff0 0 0 00000000  1 f000f000
8 00001000 80000001 00000021 00000000 0 0  0 00001000 0 80000020 0 0 00000000  1 00000002
9 00001000 80000000 0000001f 00000000 0 0  0 00001000 0 8000001c 0 0 00000000  1 00000001
10 00001000 80000000 00000004 00000000 0 0  0 00001000 0 80000004 0 0 00000000  1 f8000000
11 00001000 00000000 12345000 00000000 0 0  0 00001000 0 12345000 0 0 00000000  1 12345000
14 00002000 00000005 00000006 00000100 0 0  0 00002100 0 00000008 0 0 00000100  0 0000000b
14 00002000 00000005 00000005 00000100 0 0  1 00002100 0 00000008 0 0 00000100  0 0000000a
1 00002004 00000001 00000002 00000000 0 0  0 00002004 1 00000000 0 0 00000000  0 00000003
14 00002008 00000009 00000009 00000010 0 0  0 00002018 1 00000010 0 0 00000010  0 00000012
15 00003000 00000001 00000002 fffffff0 1 0  1 00002ff0 0 00000000 0 0 fffffff0  0 00000003
15 00003000 00000007 00000007 00000020 2 0  0 00003020 0 0000000c 0 0 00000020  0 0000000e
16 00004000 00000001 ffffffff 00000040 2 0  0 00004040 0 00000000 0 0 00000040  0 00000000
17 00004000 00000001 ffffffff 00000040 2 0  1 00004040 0 00000000 0 0 00000040  0 00000000
1 00004004 00000010 00000020 00000000 2 0  0 00004004 1 00000030 0 0 00000000  0 00000030
16 00005000 ffffffff 00000001 00000008 3 0  1 00005008 0 00000000 0 0 00000008  0 00000000
18 00005000 ffffffff 00000001 00000008 4 0  0 00005008 0 00000000 0 0 00000008  0 00000000
19 00005000 ffffffff 00000001 00000008 4 0  1 00005008 0 00000000 0 0 00000008  0 00000000
19 00005000 00000001 ffffffff 00000008 5 0  0 00005008 0 00000000 0 0 00000008  0 00000000
18 00005000 00000001 ffffffff 00000008 5 0  1 00005008 0 00000000 0 0 00000008  0 00000000
12 00006000 00006000 00000800 00000000 6 0  1 00006800 0 00006800 0 0 00000000  1 00006004
12 00006004 00006000 00000800 00000000 6 0  0 00006800 1 00006800 0 0 00000000  0 00006008
13 00007000 00008001 00000002 00000000 7 0  1 00008002 0 00008000 0 0 00000000  1 00007004
1 00008002 00000001 00000001 00000000 7 0  0 00008002 1 00000000 0 0 00000000  0 00000002
25 00000000 00001000 00000000 a1b2c3d4 0 0  0 a1b2c3d4 0 00001000 0 1 d4d4d4d4  0 00001000
25 00000000 00001000 00000001 a1b2c3d4 0 0  0 a1b2c3d4 0 00001000 0 2 d4d4d4d4  0 00001001
25 00000000 00001000 00000002 a1b2c3d4 0 0  0 a1b2c3d4 0 00001000 0 4 d4d4d4d4  0 00001002
25 00000000 00001000 00000003 a1b2c3d4 0 0  0 a1b2c3d4 0 00001000 0 8 d4d4d4d4  0 00001003
26 00000000 00001000 00000000 a1b2c3d4 0 0  0 a1b2c3d4 0 00001000 0 3 c3d4c3d4  0 00001000
26 00000000 00001000 00000002 a1b2c3d4 0 0  0 a1b2c3d4 0 00001000 0 c c3d4c3d4  0 00001002
27 00000000 00001000 00000004 a1b2c3d4 0 0  0 a1b2c3d4 0 00001004 0 f a1b2c3d4  0 00001004
20 00000000 00001000 00000003 00000000 0 0  0 00000000 0 00001000 1 0 00000000  1 00001003
22 00000000 00001000 00000002 00000000 0 0  0 00000000 0 00001000 1 0 00000000  1 00001002
24 00000000 00001000 00000008 00000000 0 0  0 00000000 0 00001008 1 0 00000000  1 00001008
1 00000000 00000100 00000200 00000000 0 1  0 00000000 0 00000300 0 0 00000000  1 00001008
1 00000000 00000100 00000200 00000000 0 0  0 00000000 0 00000300 0 0 00000000  1 00000300

// ==== all.f ====
common/exec_pkg.sv
execute/exec_alu.sv
execute/branch_unit.sv
execute/lsu_request.sv
execute/writeback_reg.sv
execute/execute.sv
bench/tb_clock.sv
bench/tb_execute.sv

// ==== Bender.yml ====
package:
  name: execute

sources:
  - common/exec_pkg.sv
  - execute/exec_alu.sv
  - execute/branch_unit.sv
  - execute/lsu_request.sv
  - execute/writeback_reg.sv
  - execute/execute.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_execute.sv

// ==== bench/tb_execute.sv ====
// Testbench for the execute stage
// Golden vector reader, drive and check loop, watchdog

`timescale 1ns/1ns

module tb_execute;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_VEC    = 64;

    logic                                 clk;
    logic                                 reset_n;
    logic                                 stall;
    logic [exec_pkg::XLEN-1:0]            pc;
    logic [exec_pkg::XLEN-1:0]            first_operand;
    logic [exec_pkg::XLEN-1:0]            second_operand;
    logic [exec_pkg::XLEN-1:0]            third_operand;
    exec_pkg::exec_op_e                   operation;
    logic [exec_pkg::TAG_W-1:0]           tag;

    logic                                 killed_o;
    logic                                 jump_o;
    logic [exec_pkg::XLEN-1:0]            jump_target_o;
    logic [exec_pkg::XLEN-1:0]            mem_address_o;
    logic                                 mem_read_enable_o;
    logic [exec_pkg::STRB_W-1:0]          mem_write_enable_o;
    logic [exec_pkg::XLEN-1:0]            mem_write_data_o;
    logic                                 write_enable_o;
    exec_pkg::exec_op_e                   instruction_operation_o;
    logic [exec_pkg::XLEN-1:0]            result_o;

    // Vector fields, inputs then expected outputs
    logic [31:0] v_op     [0:MAX_VEC-1];
    logic [31:0] v_pc     [0:MAX_VEC-1];
    logic [31:0] v_op1    [0:MAX_VEC-1];
    logic [31:0] v_op2    [0:MAX_VEC-1];
    logic [31:0] v_op3    [0:MAX_VEC-1];
    logic [31:0] v_tag    [0:MAX_VEC-1];
    logic [31:0] v_stall  [0:MAX_VEC-1];
    logic [31:0] e_jump   [0:MAX_VEC-1];
    logic [31:0] e_target [0:MAX_VEC-1];
    logic [31:0] e_killed [0:MAX_VEC-1];
    logic [31:0] e_addr   [0:MAX_VEC-1];
    logic [31:0] e_read   [0:MAX_VEC-1];
    logic [31:0] e_strb   [0:MAX_VEC-1];
    logic [31:0] e_wdata  [0:MAX_VEC-1];
    logic [31:0] e_we     [0:MAX_VEC-1];
    logic [31:0] e_result [0:MAX_VEC-1];
    int          n_vec;

    // Registered expectations, kept while stalled
    logic        exp_we;
    logic [31:0] exp_result;
    logic [5:0]  exp_op;

    tb_clock i_tb_clock (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    execute i_execute (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall),
        .pc_i                    (pc),
        .first_operand_i         (first_operand),
        .second_operand_i        (second_operand),
        .third_operand_i         (third_operand),
        .instruction_operation_i (operation),
        .tag_i                   (tag),
        .killed_o                (killed_o),
        .jump_o                  (jump_o),
        .jump_target_o           (jump_target_o),
        .mem_address_o           (mem_address_o),
        .mem_read_enable_o       (mem_read_enable_o),
        .mem_write_enable_o      (mem_write_enable_o),
        .mem_write_data_o        (mem_write_data_o),
        .write_enable_o          (write_enable_o),
        .instruction_operation_o (instruction_operation_o),
        .result_o                (result_o)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Lines starting with # are column notes
    task automatic load_vectors();
        int    fd;
        int    count;
        string line;
        fd = $fopen("bench/execute_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            $display("Simulation failed");
            $fatal(1);
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            count = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                count = $sscanf(line, "%d %h %h %h %h %d %d %d %h %d %h %d %h %h %d %h",
                    v_op[n_vec], v_pc[n_vec], v_op1[n_vec], v_op2[n_vec], v_op3[n_vec],
                    v_tag[n_vec], v_stall[n_vec], e_jump[n_vec], e_target[n_vec],
                    e_killed[n_vec], e_addr[n_vec], e_read[n_vec], e_strb[n_vec],
                    e_wdata[n_vec], e_we[n_vec], e_result[n_vec]);
                if (count != 16) begin
                    $display("Golden vector line %0d has missing fields", n_vec);
                    $display("Simulation failed");
                    $fatal(1);
                end
                n_vec++;
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////

    initial begin
        n_vec          = 0;
        stall          = 1'b0;
        pc             = '0;
        first_operand  = '0;
        second_operand = '0;
        third_operand  = '0;
        operation      = exec_pkg::NOP;
        tag            = '0;
        exp_we         = 1'b0;
        exp_result     = '0;
        exp_op         = exec_pkg::NOP;
        load_vectors();

        @(posedge reset_n);
        check_value("write_enable_o", 32'(exp_we), 32'(write_enable_o));
        check_value("result_o", exp_result, result_o);
        check_value("instruction_operation_o", 32'(exp_op), 32'(instruction_operation_o));

        for (int i = 0; i < n_vec; i++) begin
            operation      = exec_pkg::exec_op_e'(v_op[i][5:0]);
            pc             = v_pc[i];
            first_operand  = v_op1[i];
            second_operand = v_op2[i];
            third_operand  = v_op3[i];
            tag            = v_tag[i][exec_pkg::TAG_W-1:0];
            stall          = v_stall[i][0];

            // Combinational outputs settle well before the rising edge
            #(CLK_PERIOD / 2 - 2);
            check_value("jump_o", e_jump[i], 32'(jump_o));
            check_value("jump_target_o", e_target[i], jump_target_o);
            check_value("killed_o", e_killed[i], 32'(killed_o));
            check_value("mem_address_o", e_addr[i], mem_address_o);
            check_value("mem_read_enable_o", e_read[i], 32'(mem_read_enable_o));
            check_value("mem_write_enable_o", e_strb[i], 32'(mem_write_enable_o));
            check_value("mem_write_data_o", e_wdata[i], mem_write_data_o);

            if (!v_stall[i][0]) begin
                exp_we     = e_we[i][0];
                exp_result = e_result[i];
                exp_op     = v_op[i][5:0];
            end

            @(posedge clk);
            #1;
            check_value("write_enable_o", 32'(exp_we), 32'(write_enable_o));
            check_value("result_o", exp_result, result_o);
            check_value("instruction_operation_o", 32'(exp_op),
                        32'(instruction_operation_o));
            @(negedge clk);
        end

        if (n_vec == 0) begin
            $display("No golden vectors were found");
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    // Vectors take one cycle each, plus reset and margin
    initial begin
        #1;
        #((n_vec + 10) * CLK_PERIOD);
        $display("Timeout: the vectors did not finish in time");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// ==== bench/tb_clock.sv ====
// Testbench clock and reset source
// 20 ns clock, reset held low over the first two rising edges

`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic reset_n_o
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the flops
    initial begin
        reset_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

endmodule

// ==== execute/execute.sv ====
// Execute stage top level
// ALU, branch/tag unit, load/store request and write-back register

`timescale 1ns/1ns

module execute (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         stall_i,
    input  logic [exec_pkg::XLEN-1:0]    pc_i,
    input  logic [exec_pkg::XLEN-1:0]    first_operand_i,
    input  logic [exec_pkg::XLEN-1:0]    second_operand_i,
    input  logic [exec_pkg::XLEN-1:0]    third_operand_i,
    input  exec_pkg::exec_op_e           instruction_operation_i,
    input  logic [exec_pkg::TAG_W-1:0]   tag_i,

    output logic                         killed_o,
    output logic                         jump_o,
    output logic [exec_pkg::XLEN-1:0]    jump_target_o,

    output logic [exec_pkg::XLEN-1:0]    mem_address_o,
    output logic                         mem_read_enable_o,
    output logic [exec_pkg::STRB_W-1:0]  mem_write_enable_o,
    output logic [exec_pkg::XLEN-1:0]    mem_write_data_o,

    output logic                         write_enable_o,
    output exec_pkg::exec_op_e           instruction_operation_o,
    output logic [exec_pkg::XLEN-1:0]    result_o
);

    logic [exec_pkg::XLEN-1:0] sum;
    logic [exec_pkg::XLEN-1:0] link_sum;
    logic [exec_pkg::XLEN-1:0] alu_result;
    logic                      equal;
    logic                      less_than;
    logic                      less_than_unsigned;

    exec_alu i_exec_alu (
        .pc_i                    (pc_i),
        .first_operand_i         (first_operand_i),
        .second_operand_i        (second_operand_i),
        .third_operand_i         (third_operand_i),
        .instruction_operation_i (instruction_operation_i),
        .sum_o                   (sum),
        .link_sum_o              (link_sum),
        .alu_result_o            (alu_result),
        .equal_o                 (equal),
        .less_than_o             (less_than),
        .less_than_unsigned_o    (less_than_unsigned)
    );

    branch_unit i_branch_unit (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .instruction_operation_i (instruction_operation_i),
        .tag_i                   (tag_i),
        .sum_i                   (sum),
        .link_sum_i              (link_sum),
        .equal_i                 (equal),
        .less_than_i             (less_than),
        .less_than_unsigned_i    (less_than_unsigned),
        .killed_o                (killed_o),
        .jump_o                  (jump_o),
        .jump_target_o           (jump_target_o)
    );

    lsu_request i_lsu_request (
        .instruction_operation_i (instruction_operation_i),
        .sum_i                   (sum),
        .third_operand_i         (third_operand_i),
        .mem_address_o           (mem_address_o),
        .mem_read_enable_o       (mem_read_enable_o),
        .mem_write_enable_o      (mem_write_enable_o),
        .mem_write_data_o        (mem_write_data_o)
    );

    writeback_reg i_writeback_reg (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall_i),
        .instruction_operation_i (instruction_operation_i),
        .alu_result_i            (alu_result),
        .link_sum_i              (link_sum),
        .killed_i                (killed_o),
        .write_enable_o          (write_enable_o),
        .instruction_operation_o (instruction_operation_o),
        .result_o                (result_o)
    );

endmodule

// ==== execute/writeback_reg.sv ====
// Write-back output register of the execute stage
// Result select, write enable, hold under stall

`timescale 1ns/1ns

module writeback_reg (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       stall_i,
    input  exec_pkg::exec_op_e         instruction_operation_i,
    input  logic [exec_pkg::XLEN-1:0]  alu_result_i,
    input  logic [exec_pkg::XLEN-1:0]  link_sum_i,
    input  logic                       killed_i,
    output logic                       write_enable_o,
    output exec_pkg::exec_op_e         instruction_operation_o,
    output logic [exec_pkg::XLEN-1:0]  result_o
);

    logic [exec_pkg::XLEN-1:0] result;
    logic                      write_enable;

    // Link value and SUB both come from the second adder
    assign result = (instruction_operation_i inside
                     {exec_pkg::JAL, exec_pkg::JALR, exec_pkg::SUB}) ? link_sum_i
                                                                     : alu_result_i;

    always_comb begin
        case (instruction_operation_i)
            exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE,
            exec_pkg::BLT, exec_pkg::BLTU,
            exec_pkg::BGE, exec_pkg::BGEU: write_enable = 1'b0;
            default:                       write_enable = ~killed_i;
        endcase
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o          <= 1'b0;
            instruction_operation_o <= exec_pkg::NOP;
            result_o                <= '0;
        end else if (!stall_i) begin
            write_enable_o          <= write_enable;
            instruction_operation_o <= instruction_operation_i;
            result_o                <= result;
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable(write_enable_o) && $stable(instruction_operation_o) &&
                    $stable(result_o));

endmodule

// ==== execute/lsu_request.sv ====
// Load and store request generation
// Aligned address, read enable, byte strobes, store data

`timescale 1ns/1ns

module lsu_request (
    input  exec_pkg::exec_op_e           instruction_operation_i,
    input  logic [exec_pkg::XLEN-1:0]    sum_i,
    input  logic [exec_pkg::XLEN-1:0]    third_operand_i,
    output logic [exec_pkg::XLEN-1:0]    mem_address_o,
    output logic                         mem_read_enable_o,
    output logic [exec_pkg::STRB_W-1:0]  mem_write_enable_o,
    output logic [exec_pkg::XLEN-1:0]    mem_write_data_o
);

    // Word aligned, byte lanes chosen by the strobes
    assign mem_address_o = {sum_i[exec_pkg::XLEN-1:2], 2'b00};

    assign mem_read_enable_o = instruction_operation_i inside
        {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH, exec_pkg::LHU, exec_pkg::LW};

    always_comb begin
        case (instruction_operation_i)
            exec_pkg::SB: mem_write_data_o = {exec_pkg::STRB_W{third_operand_i[7:0]}};
            exec_pkg::SH: mem_write_data_o = {(exec_pkg::STRB_W/2){third_operand_i[15:0]}};
            default:      mem_write_data_o = third_operand_i;
        endcase
    end

    always_comb begin
        case (instruction_operation_i)
            exec_pkg::SB: mem_write_enable_o = exec_pkg::STRB_W'(1) << sum_i[1:0];
            exec_pkg::SH: mem_write_enable_o = sum_i[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: mem_write_enable_o = '1;
            default:      mem_write_enable_o = '0;
        endcase
    end

endmodule

// ==== execute/branch_unit.sv ====
// Branch decision, jump target and flow tag
// Kills instructions whose tag is stale

`timescale 1ns/1ns

module branch_unit (
    input  logic                        clk,
    input  logic                        reset_n,
    input  exec_pkg::exec_op_e          instruction_operation_i,
    input  logic [exec_pkg::TAG_W-1:0]  tag_i,
    input  logic [exec_pkg::XLEN-1:0]   sum_i,
    input  logic [exec_pkg::XLEN-1:0]   link_sum_i,
    input  logic                        equal_i,
    input  logic                        less_than_i,
    input  logic                        less_than_unsigned_i,
    output logic                        killed_o,
    output logic                        jump_o,
    output logic [exec_pkg::XLEN-1:0]   jump_target_o
);

    logic [exec_pkg::TAG_W-1:0] curr_tag;
    logic                       jump;

    assign killed_o = (tag_i != curr_tag);

    //////////////////////////////
    // Jump decision
    //////////////////////////////

    always_comb begin
        case (instruction_operation_i)
            exec_pkg::BEQ:  jump = equal_i;
            exec_pkg::BNE:  jump = ~equal_i;
            exec_pkg::BLT:  jump = less_than_i;
            exec_pkg::BLTU: jump = less_than_unsigned_i;
            exec_pkg::BGE:  jump = ~less_than_i;
            exec_pkg::BGEU: jump = ~less_than_unsigned_i;
            exec_pkg::JAL,
            exec_pkg::JALR: jump = 1'b1;
            default:        jump = 1'b0;
        endcase
    end

    assign jump_o = jump & ~killed_o;

    // Branch targets come from the pc + offset adder
    always_comb begin
        case (instruction_operation_i)
            exec_pkg::JALR: jump_target_o = {sum_i[exec_pkg::XLEN-1:1], 1'b0};
            exec_pkg::JAL:  jump_target_o = sum_i;
            default:        jump_target_o = link_sum_i;
        endcase
    end

    // New flow on every taken jump, wraps modulo 8
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end else if (jump_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    // The same tag is stale right after a jump
    a_tag_advance: assert property (@(posedge clk) disable iff (!reset_n)
        jump_o |=> curr_tag == $past(tag_i) + 1'b1);

endmodule

// ==== execute/exec_alu.sv ====
// Integer ALU of the execute stage
// Operand adder, link/sub adder, logic, shifts and compares

`timescale 1ns/1ns

module exec_alu (
    input  logic [exec_pkg::XLEN-1:0]  pc_i,
    input  logic [exec_pkg::XLEN-1:0]  first_operand_i,
    input  logic [exec_pkg::XLEN-1:0]  second_operand_i,
    input  logic [exec_pkg::XLEN-1:0]  third_operand_i,
    input  exec_pkg::exec_op_e         instruction_operation_i,
    output logic [exec_pkg::XLEN-1:0]  sum_o,
    output logic [exec_pkg::XLEN-1:0]  link_sum_o,
    output logic [exec_pkg::XLEN-1:0]  alu_result_o,
    output logic                       equal_o,
    output logic                       less_than_o,
    output logic                       less_than_unsigned_o
);

    logic [exec_pkg::SHAMT_W-1:0] shamt;
    logic [exec_pkg::XLEN-1:0]    sum2_op_a;
    logic [exec_pkg::XLEN-1:0]    sum2_op_b;
    logic [exec_pkg::XLEN-1:0]    sll_result;
    logic [exec_pkg::XLEN-1:0]    srl_result;
    logic [exec_pkg::XLEN-1:0]    sra_result;

    assign shamt = second_operand_i[exec_pkg::SHAMT_W-1:0];

    //////////////////////////////
    // Adders
    //////////////////////////////

    assign sum_o = first_operand_i + second_operand_i;

    // SUB reuses the link adder, branches get pc + offset
    always_comb begin
        sum2_op_a = pc_i;
        sum2_op_b = third_operand_i;
        if (instruction_operation_i == exec_pkg::SUB) begin
            sum2_op_a = first_operand_i;
            sum2_op_b = -second_operand_i;
        end else if (instruction_operation_i inside {exec_pkg::JAL, exec_pkg::JALR}) begin
            sum2_op_b = exec_pkg::LINK_OFFSET;
        end
    end

    assign link_sum_o = sum2_op_a + sum2_op_b;

    //////////////////////////////
    // Shifts and compares
    //////////////////////////////

    assign sll_result = first_operand_i << shamt;
    assign srl_result = first_operand_i >> shamt;
    assign sra_result = $signed(first_operand_i) >>> shamt;

    assign equal_o              = (first_operand_i == second_operand_i);
    assign less_than_o          = ($signed(first_operand_i) < $signed(second_operand_i));
    assign less_than_unsigned_o = (first_operand_i < second_operand_i);

    // Result mux
    always_comb begin
        case (instruction_operation_i)
            exec_pkg::SLT:  alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, less_than_o};
            exec_pkg::SLTU: alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, less_than_unsigned_o};
            exec_pkg::LUI:  alu_result_o = second_operand_i;
            exec_pkg::XOR:  alu_result_o = first_operand_i ^ second_operand_i;
            exec_pkg::OR:   alu_result_o = first_operand_i | second_operand_i;
            exec_pkg::AND:  alu_result_o = first_operand_i & second_operand_i;
            exec_pkg::SLL:  alu_result_o = sll_result;
            exec_pkg::SRL:  alu_result_o = srl_result;
            exec_pkg::SRA:  alu_result_o = sra_result;
            default:        alu_result_o = sum_o;
        endcase
    end

endmodule

// ==== common/exec_pkg.sv ====
// Shared definitions for the RV32I execute stage
// Decoded operation enum and width constants

package exec_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Data and address width
    localparam int XLEN    = 32;
    // Flow tag width
    localparam int TAG_W   = 3;
    // Shift amount bits taken from operand two
    localparam int SHAMT_W = 5;
    // Byte strobes per word
    localparam int STRB_W  = XLEN / 8;

    // Link increment for JAL and JALR
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

    //////////////////////////////
    // Decoded operation
    //////////////////////////////

    typedef enum logic [5:0] {
        NOP  = 6'd0,
        ADD  = 6'd1,
        SUB  = 6'd2,
        SLT  = 6'd3,
        SLTU = 6'd4,
        XOR  = 6'd5,
        OR   = 6'd6,
        AND  = 6'd7,
        SLL  = 6'd8,
        SRL  = 6'd9,
        SRA  = 6'd10,
        LUI  = 6'd11,
        JAL  = 6'd12,
        JALR = 6'd13,
        BEQ  = 6'd14,
        BNE  = 6'd15,
        BLT  = 6'd16,
        BLTU = 6'd17,
        BGE  = 6'd18,
        BGEU = 6'd19,
        LB   = 6'd20,
        LBU  = 6'd21,
        LH   = 6'd22,
        LHU  = 6'd23,
        LW   = 6'd24,
        SB   = 6'd25,
        SH   = 6'd26,
        SW   = 6'd27
    } exec_op_e;

endpackage
